// File: noncomp_slice.f
hw/fpslice_pkg.sv
hw/lane_out_if.sv
hw/noncomp_lane.sv
hw/result_packer.sv
hw/noncomp_slice.sv
test/tb_noncomp_slice.sv

// File: Bender.yml
package:
  name: noncomp_slice

sources:
  - files:
      - hw/fpslice_pkg.sv
      - hw/lane_out_if.sv
      - hw/noncomp_lane.sv
      - hw/result_packer.sv
      - hw/noncomp_slice.sv
  - target: test
    files:
      - test/tb_noncomp_slice.sv

// File: test/tb_noncomp_slice.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noncomp_slice;

  import fpslice_pkg::*;

  localparam int unsigned WIDTH     = 64;
  localparam int unsigned NUM_LANES = 4;
  localparam int unsigned TIMEOUT   = 50;

  typedef logic [1:0][WIDTH-1:0] operands_t;

  typedef struct packed {
    logic [WIDTH-1:0] word;
    status_t          status;
  } expect_t;

  logic                 clk_i;
  logic                 rst_n_i;
  operands_t            operands_i;
  op_e                  op_i;
  fp_format_e           fmt_i;
  logic                 vectorial_op_i;
  tag_t                 tag_i;
  logic [NUM_LANES-1:0] simd_mask_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic                 flush_i;
  logic [WIDTH-1:0]     result_o;
  status_t              status_o;
  tag_t                 tag_o;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic                 busy_o;

  logic [31:0] rng_state = 32'haaefe711;
  expect_t     exp_q[$];
  tag_t        tag_q[$];

  noncomp_slice #(
    .Width       ( WIDTH ),
    .NumPipeRegs ( 2     )
  ) UUT (
    .*
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Random operands
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [WIDTH-1:0] rand_word();
    logic [31:0] hi;
    hi        = xorshift32(rng_state);
    rng_state = xorshift32(hi);
    return {hi, rng_state};
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Exponent all ones with a nonzero fraction
  function automatic logic is_nan(logic [31:0] x, int w);
    if (w == 32) return (x[30:23] == 8'hFF) && (x[22:0] != '0);
    return (x[14:10] == 5'h1F) && (x[9:0] != '0);
  endfunction

  function automatic logic is_snan(logic [31:0] x, int w);
    return is_nan(x, w) && !((w == 32) ? x[22] : x[9]);
  endfunction

  // Unsigned key with the same order as the FP value so -0 sorts just below +0
  function automatic logic [31:0] order_key(logic [31:0] x, int w);
    logic [31:0] msb;
    msb = (w == 32) ? 32'h8000_0000 : 32'h0000_8000;
    return (x & msb) ? (~x & (msb | (msb - 1))) : (x | msb);
  endfunction

  function automatic logic [31:0] ref_elem(logic [31:0] a_in, logic [31:0] b_in, op_e op,
                                           int w);
    logic [31:0] msb;
    logic [31:0] a;
    logic [31:0] b;
    logic        take_a;
    msb = (w == 32) ? 32'h8000_0000 : 32'h0000_8000;
    a   = a_in & (msb | (msb - 1));
    b   = b_in & (msb | (msb - 1));
    case (op)
      FSGNJ:  return (a & ~msb) | (b & msb);
      FSGNJN: return (a & ~msb) | (~b & msb);
      FSGNJX: return a ^ (b & msb);
      default: begin
        if (is_nan(a, w) && is_nan(b, w)) return (w == 32) ? 32'h7FC0_0000 : 32'h0000_7E00;
        if (is_nan(a, w)) return b;
        if (is_nan(b, w)) return a;
        take_a = (op == FMIN) ? (order_key(a, w) <= order_key(b, w))
                              : (order_key(a, w) >= order_key(b, w));
        return take_a ? a : b;
      end
    endcase
  endfunction

  // Whole output word with NaN-boxing above the last lane in use
  function automatic expect_t expect_model(operands_t ops, op_e op, fp_format_e fmt,
                                           logic vec, logic [NUM_LANES-1:0] mask);
    expect_t          res;
    int               w;
    int               used;
    logic [WIDTH-1:0] field;
    logic [WIDTH-1:0] sa;
    logic [WIDTH-1:0] sb;
    w          = (fmt == FP16) ? 16 : 32;
    used       = vec ? WIDTH / w : 1;
    field      = (w == 32) ? 64'hFFFF_FFFF : 64'hFFFF;
    res.word   = '1;
    res.status = '0;
    for (int l = 0; l < used; l++) begin
      sa       = ops[0] >> (l * w);
      sb       = ops[1] >> (l * w);
      res.word = (res.word & ~(field << (l * w))) |
                 (({32'h0, ref_elem(sa[31:0], sb[31:0], op, w)} & field) << (l * w));
      if (mask[l] && (op == FMIN || op == FMAX) &&
          (is_snan(sa[31:0], w) || is_snan(sb[31:0], w))) begin
        res.status.nv = 1'b1;
      end
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Checks and handshakes
  // --------------------------------------------------
  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_result(logic [WIDTH-1:0] got, logic [WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL result_o: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(status_t got, status_t exp);
    if (got !== exp) begin
      $display("FAIL status_o: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_tag(tag_t got, tag_t exp);
    if (got !== exp) begin
      $display("FAIL tag_o: got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic send_item(operands_t ops, op_e op, fp_format_e fmt, logic vec, tag_t tag,
                           logic [NUM_LANES-1:0] mask);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    operands_i     <= ops;
    op_i           <= op;
    fmt_i          <= fmt;
    vectorial_op_i <= vec;
    tag_i          <= tag;
    simd_mask_i    <= mask;
    in_valid_i     <= 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) begin
      if (cycles == TIMEOUT) begin
        $display("Timeout, in_ready_o never went high for tag %h", tag);
        abort_run();
      end
      cycles++;
      @(negedge clk_i);
    end
    // Accepted on this edge
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic receive_item(expect_t exp, tag_t tag);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!out_valid_o) begin
      if (cycles == TIMEOUT) begin
        $display("Timeout, no result arrived for tag %h", tag);
        abort_run();
      end
      cycles++;
      @(negedge clk_i);
    end
    check_result(result_o, exp.word);
    check_status(status_o, exp.status);
    check_tag(tag_o, tag);
    @(posedge clk_i);
  endtask

  task automatic run_item(operands_t ops, op_e op, fp_format_e fmt, logic vec, tag_t tag,
                          logic [NUM_LANES-1:0] mask);
    send_item(ops, op, fmt, vec, tag, mask);
    receive_item(expect_model(ops, op, fmt, vec, mask), tag);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_sign_injection();
    operands_t ops;
    for (int i = 0; i < 12; i++) begin
      ops[0] = rand_word();
      ops[1] = rand_word();
      // FSGNJ, FSGNJN and FSGNJX in turn
      run_item(ops, op_e'(i % 3), FP32, 1'b0, tag_t'(8'h10 + i), '1);
    end
  endtask

  task automatic test_fp16_minmax();
    operands_t ops;
    for (int i = 0; i < 8; i++) begin
      ops[0] = rand_word();
      ops[1] = rand_word();
      run_item(ops, (i % 2 == 1) ? FMAX : FMIN, FP16, 1'b1, tag_t'(8'h20 + i), '1);
    end
    // Signed zero pairs in both orders
    ops[0] = 64'h8000_0000_8000_0000;
    ops[1] = 64'h0000_8000_0000_8000;
    run_item(ops, FMIN, FP16, 1'b1, 8'h2A, '1);
    run_item(ops, FMAX, FP16, 1'b1, 8'h2B, '1);
  endtask

  task automatic test_nan_status();
    operands_t ops;
    // Signaling NaN in lane 1 of an FP32 vector
    ops[0] = {32'h7F80_0001, 32'h3F80_0000};
    ops[1] = {32'hC000_0000, 32'h4000_0000};
    run_item(ops, FMIN, FP32, 1'b1, 8'h30, 4'b0011);
    run_item(ops, FMIN, FP32, 1'b1, 8'h31, 4'b0001);
    // Both operands NaN
    ops[0] = {32'h0, 32'h7FC0_0001};
    ops[1] = {32'h0, 32'hFF80_0005};
    run_item(ops, FMAX, FP32, 1'b0, 8'h32, '1);
    ops[0] = 64'h3C00_7D00_3C00_3C00;
    ops[1] = 64'h4000_FE01_4000_4000;
    run_item(ops, FMIN, FP16, 1'b1, 8'h33, '1);
  endtask

  task automatic test_backpressure();
    operands_t ops;
    int        sent;
    sent = 0;
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    while (1) begin
      ops[0] = rand_word();
      ops[1] = rand_word();
      exp_q.push_back(expect_model(ops, FMAX, FP32, 1'b1, '1));
      tag_q.push_back(tag_t'(8'h40 + sent));
      send_item(ops, FMAX, FP32, 1'b1, tag_t'(8'h40 + sent), '1);
      sent++;
      @(negedge clk_i);
      if (!in_ready_o) break;
      if (sent == 8) begin
        $display("in_ready_o stayed high while the output was stalled");
        abort_run();
      end
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    while (exp_q.size() > 0) begin
      receive_item(exp_q.pop_front(), tag_q.pop_front());
    end
    // No duplicate after the last item
    repeat (4) begin
      @(negedge clk_i);
      check_flag("out_valid_o", out_valid_o, 1'b0);
    end
  endtask

  task automatic test_flush();
    operands_t ops;
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    for (int i = 0; i < 2; i++) begin
      ops[0] = rand_word();
      ops[1] = rand_word();
      send_item(ops, FSGNJX, FP16, 1'b1, tag_t'(8'h50 + i), '1);
    end
    // Both items wait in the pipeline
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b1);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i     <= 1'b0;
    out_ready_i <= 1'b1;
    repeat (10) begin
      @(negedge clk_i);
      check_flag("out_valid_o", out_valid_o, 1'b0);
    end
    check_flag("busy_o", busy_o, 1'b0);
    ops[0] = rand_word();
    ops[1] = rand_word();
    run_item(ops, FMIN, FP16, 1'b1, 8'h5F, '1);
  endtask

  initial begin : main
    rst_n_i        = 1'b0;
    operands_i     = '0;
    op_i           = FSGNJ;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_sign_injection();
    test_fp16_minmax();
    test_nan_status();
    test_backpressure();
    test_flush();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/noncomp_slice.sv
`timescale 1ns/1ps
`default_nettype none

module noncomp_slice #(
  parameter  int unsigned Width         = 64,
  parameter  int unsigned NumPipeRegs   = 2,
  parameter  logic        EnableVectors = 1'b1,
  localparam int unsigned NUM_LANES     = fpslice_pkg::num_lanes(Width)
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Operation
  input  logic [1:0][Width-1:0]   operands_i,
  input  fpslice_pkg::op_e        op_i,
  input  fpslice_pkg::fp_format_e fmt_i,
  input  logic                    vectorial_op_i,
  input  fpslice_pkg::tag_t       tag_i,
  input  logic [NUM_LANES-1:0]    simd_mask_i,
  // Input handshake
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic                    flush_i,
  // Result
  output logic [Width-1:0]        result_o,
  output fpslice_pkg::status_t    status_o,
  output fpslice_pkg::tag_t       tag_o,
  // Output handshake
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  import fpslice_pkg::*;

  logic                 vectorial_op;
  aux_t                 aux_data;
  logic [NUM_LANES-1:0] lane_in_valid;
  logic [NUM_LANES-1:0] lane_in_ready;
  logic [NUM_LANES-1:0] lane_busy;

  lane_out_if lane_if [NUM_LANES] ();

  // --------------------------------------------------
  // Input side
  // --------------------------------------------------
  assign vectorial_op = vectorial_op_i & EnableVectors;
  assign aux_data     = '{fmt: fmt_i, vectorial: vectorial_op};

  // All lanes in use share one ready, lane 0 speaks for them
  assign in_ready_o = lane_in_ready[0];

  // --------------------------------------------------
  // Lanes
  // --------------------------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    localparam fmt_logic_t LANE_FMTS = lane_formats(Width, l);

    logic [1:0][MAX_FP_WIDTH-1:0] local_operands;

    // Each lane sees its own slot at the bottom, upper bits are ignored
    always_comb begin : slice_operands
      logic [Width-1:0] shifted;
      for (int i = 0; i < 2; i++) begin
        shifted           = operands_i[i] >> (l * fp_width(fmt_i));
        local_operands[i] = shifted[MAX_FP_WIDTH-1:0];
      end
    end

    // Upper lanes start only together with lane 0
    assign lane_in_valid[l] = in_valid_i &
        ((l == 0) | (in_ready_o & vectorial_op & LANE_FMTS[fmt_i]));

    noncomp_lane #(
      .LaneFormats ( LANE_FMTS   ),
      .NumPipeRegs ( NumPipeRegs )
    ) i_noncomp_lane (
      .clk_i,
      .rst_n_i,
      .operands_i ( local_operands   ),
      .op_i,
      .fmt_i,
      .tag_i,
      .mask_i     ( simd_mask_i[l]   ),
      .aux_i      ( aux_data         ),
      .in_valid_i ( lane_in_valid[l] ),
      .in_ready_o ( lane_in_ready[l] ),
      .flush_i,
      .busy_o     ( lane_busy[l]     ),
      .out_if     ( lane_if[l]       )
    );

    if (l > 0) begin : gen_sync_check
      // An upper lane never misses an item that lane 0 accepts
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
          lane_in_valid[l] |-> lane_in_ready[l])
        else $error("upper lane not ready while lane 0 accepts a vector");
    end
  end

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  result_packer #(
    .Width ( Width )
  ) i_result_packer (
    .out_ready_i,
    .result_o,
    .status_o,
    .tag_o,
    .out_valid_o,
    .lanes       ( lane_if )
  );

  assign busy_o = |lane_busy;

endmodule

`default_nettype wire

// File: hw/result_packer.sv
`timescale 1ns/1ps
`default_nettype none

module result_packer #(
  parameter  int unsigned Width     = 64,
  localparam int unsigned NUM_LANES = fpslice_pkg::num_lanes(Width)
) (
  input  logic                 out_ready_i,
  output logic [Width-1:0]     result_o,
  output fpslice_pkg::status_t status_o,
  output fpslice_pkg::tag_t    tag_o,
  output logic                 out_valid_o,
  lane_out_if.packer           lanes [NUM_LANES]
);

  import fpslice_pkg::*;

  aux_t                              res_aux;
  logic    [NUM_LANES-1:0]           lane_used;
  status_t [NUM_LANES-1:0]           lane_status;
  logic    [NUM_FORMATS-1:0][Width-1:0] fmt_slice;

  // Format and vector flag of the item at the head of lane 0
  assign res_aux = lanes[0].aux;

  // --------------------------------------------------
  // Per-lane handshake and packing
  // --------------------------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    localparam fmt_logic_t LANE_FMTS = lane_formats(Width, l);

    // Upper lanes only take part in vectors of a format they hold
    if (l == 0) begin : gen_first
      assign lane_used[l] = 1'b1;
    end else begin : gen_upper
      assign lane_used[l] = res_aux.vectorial & LANE_FMTS[res_aux.fmt];
    end

    assign lanes[l].ready = out_ready_i & lane_used[l];

    assign lane_status[l] = (lanes[l].valid & lane_used[l] & lanes[l].mask)
                            ? lanes[l].status : '0;

    for (genvar f = 0; f < NUM_FORMATS; f++) begin : gen_fmt
      localparam int unsigned FP_WIDTH = fp_width(fp_format_e'(f));

      if (LANE_FMTS[f]) begin : gen_slot
        // Slots of idle lanes are NaN-boxed
        assign fmt_slice[f][l*FP_WIDTH +: FP_WIDTH] =
            lane_used[l] ? lanes[l].result[FP_WIDTH-1:0] : '1;
      end
    end
  end

  // Bits above the last slot of a format
  for (genvar f = 0; f < NUM_FORMATS; f++) begin : gen_box
    localparam int unsigned FP_WIDTH  = fp_width(fp_format_e'(f));
    localparam int unsigned USED_BITS = (Width / FP_WIDTH) * FP_WIDTH;

    if (USED_BITS < Width) begin : gen_upper_ones
      assign fmt_slice[f][Width-1:USED_BITS] = '1;
    end
  end

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  assign result_o    = fmt_slice[res_aux.fmt];
  assign out_valid_o = lanes[0].valid;
  assign tag_o       = lanes[0].tag;

  // Flags of all lanes in use, filtered by the SIMD mask
  always_comb begin : collapse_status
    status_o = '0;
    for (int l = 0; l < int'(NUM_LANES); l++) begin
      status_o = status_o | lane_status[l];
    end
  end

endmodule

`default_nettype wire

// File: hw/noncomp_lane.sv
`timescale 1ns/1ps
`default_nettype none

module noncomp_lane #(
  parameter fpslice_pkg::fmt_logic_t LaneFormats = '1,
  parameter int unsigned             NumPipeRegs = 2
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [1:0][fpslice_pkg::MAX_FP_WIDTH-1:0] operands_i,
  input  fpslice_pkg::op_e                          op_i,
  input  fpslice_pkg::fp_format_e                   fmt_i,
  input  fpslice_pkg::tag_t                         tag_i,
  input  logic                                      mask_i,
  input  fpslice_pkg::aux_t                         aux_i,
  input  logic                                      in_valid_i,
  output logic                                      in_ready_o,
  input  logic                                      flush_i,
  output logic                                      busy_o,
  lane_out_if.lane                                  out_if
);

  import fpslice_pkg::*;

  fp_format_e              fmt;
  logic [MAX_FP_WIDTH-1:0] op_a;
  logic [MAX_FP_WIDTH-1:0] op_b;
  logic [MAX_FP_WIDTH-1:0] sign_mask;
  logic [MAX_FP_WIDTH-1:0] box_mask;
  logic [MAX_FP_WIDTH-1:0] inf_mag;
  logic [MAX_FP_WIDTH-1:0] qbit_mask;
  logic [MAX_FP_WIDTH-1:0] mag_a;
  logic [MAX_FP_WIDTH-1:0] mag_b;
  logic                    sign_a;
  logic                    sign_b;
  logic                    nan_a;
  logic                    nan_b;
  logic                    snan_a;
  logic                    snan_b;
  logic                    a_less;
  logic [MAX_FP_WIDTH-1:0] op_result;
  status_t                 op_status;

  // Pipeline signals where index i holds the item after i register stages
  logic    [0:NumPipeRegs]                   pipe_valid_q;
  logic    [0:NumPipeRegs][MAX_FP_WIDTH-1:0] pipe_result_q;
  status_t [0:NumPipeRegs]                   pipe_status_q;
  tag_t    [0:NumPipeRegs]                   pipe_tag_q;
  logic    [0:NumPipeRegs]                   pipe_mask_q;
  aux_t    [0:NumPipeRegs]                   pipe_aux_q;
  logic    [0:NumPipeRegs]                   pipe_ready;

  // --------------------------------------------------
  // Operand decode
  // --------------------------------------------------
  // FP32 logic drops out in lanes that only hold FP16
  assign fmt  = (LaneFormats[FP32] && (fmt_i == FP32)) ? FP32 : FP16;
  assign op_a = operands_i[0];
  assign op_b = operands_i[1];

  always_comb begin : fmt_constants
    if (fmt == FP32) begin
      sign_mask = 32'h8000_0000;
      box_mask  = 32'h0000_0000;
      inf_mag   = 32'h7F80_0000;
      qbit_mask = 32'h0040_0000;
    end else begin
      sign_mask = 32'h0000_8000;
      box_mask  = 32'hFFFF_0000;
      inf_mag   = 32'h0000_7C00;
      qbit_mask = 32'h0000_0200;
    end
  end

  assign sign_a = |(op_a & sign_mask);
  assign sign_b = |(op_b & sign_mask);
  assign mag_a  = op_a & ~(sign_mask | box_mask);
  assign mag_b  = op_b & ~(sign_mask | box_mask);

  // Anything above infinity is a NaN
  // A NaN with a clear quiet bit is signaling
  assign nan_a  = mag_a > inf_mag;
  assign nan_b  = mag_b > inf_mag;
  assign snan_a = nan_a & ~|(op_a & qbit_mask);
  assign snan_b = nan_b & ~|(op_b & qbit_mask);

  // Sign-magnitude ordering where -0 sorts below +0
  always_comb begin : order
    if (sign_a != sign_b) begin
      a_less = sign_a;
    end else if (sign_a) begin
      a_less = mag_a > mag_b;
    end else begin
      a_less = mag_a < mag_b;
    end
  end

  // --------------------------------------------------
  // Stage 0 operation
  // --------------------------------------------------
  always_comb begin : compute
    op_result = '1;
    op_status = '0;
    case (op_i)
      FSGNJ:  op_result = box_mask | (sign_b ? sign_mask : '0) | mag_a;
      FSGNJN: op_result = box_mask | (sign_b ? '0 : sign_mask) | mag_a;
      FSGNJX: op_result = box_mask | ((sign_a ^ sign_b) ? sign_mask : '0) | mag_a;
      FMIN, FMAX: begin
        if (nan_a && nan_b) begin
          op_result = box_mask | canonical_nan(fmt);
        end else if (nan_a) begin
          op_result = box_mask | op_b;
        end else if (nan_b) begin
          op_result = box_mask | op_a;
        end else if (a_less == (op_i == FMIN)) begin
          op_result = box_mask | op_a;
        end else begin
          op_result = box_mask | op_b;
        end
        op_status.nv = snan_a | snan_b;
      end
      default: op_result = '1;
    endcase
  end

  // --------------------------------------------------
  // Register pipeline
  // --------------------------------------------------
  assign pipe_valid_q[0]  = in_valid_i;
  assign pipe_result_q[0] = op_result;
  assign pipe_status_q[0] = op_status;
  assign pipe_tag_q[0]    = tag_i;
  assign pipe_mask_q[0]   = mask_i;
  assign pipe_aux_q[0]    = aux_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe
    logic reg_ena;

    // Advance if the next stage moves on or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];
    assign reg_ena       = pipe_ready[i] & pipe_valid_q[i];

    always_ff @(posedge clk_i) begin : valid_reg
      if (!rst_n_i || flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_regs
      if (reg_ena) begin
        pipe_result_q[i+1] <= pipe_result_q[i];
        pipe_status_q[i+1] <= pipe_status_q[i];
        pipe_tag_q[i+1]    <= pipe_tag_q[i];
        pipe_mask_q[i+1]   <= pipe_mask_q[i];
        pipe_aux_q[i+1]    <= pipe_aux_q[i];
      end
    end
  end

  assign pipe_ready[NumPipeRegs] = out_if.ready;
  assign in_ready_o              = pipe_ready[0];
  assign busy_o                  = |pipe_valid_q;

  assign out_if.valid  = pipe_valid_q[NumPipeRegs];
  assign out_if.result = pipe_result_q[NumPipeRegs];
  assign out_if.status = pipe_status_q[NumPipeRegs];
  assign out_if.tag    = pipe_tag_q[NumPipeRegs];
  assign out_if.mask   = pipe_mask_q[NumPipeRegs];
  assign out_if.aux    = pipe_aux_q[NumPipeRegs];

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  if (NumPipeRegs > 0) begin : gen_hold_check
    // A stalled output item waits for the packer unchanged
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_if.valid && !out_if.ready && !flush_i) |=>
        (out_if.valid && $stable(out_if.result) && $stable(out_if.status) &&
         $stable(out_if.tag) && $stable(out_if.mask) && $stable(out_if.aux)))
      else $error("lane output changed while stalled");
  end

  // Top level only issues formats this lane holds
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_valid_i |-> LaneFormats[fmt_i])
    else $error("lane issued a format it does not hold");

endmodule

`default_nettype wire

// File: hw/lane_out_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lane_out_if;

  import fpslice_pkg::*;

  // Handshake
  logic                    valid;
  logic                    ready;

  // Payload, held while valid is high and ready is low
  logic [MAX_FP_WIDTH-1:0] result;
  status_t                 status;
  tag_t                    tag;
  logic                    mask;   // SIMD mask bit of this lane
  aux_t                    aux;

  modport lane (
    output valid,
    input  ready,
    output result,
    output status,
    output tag,
    output mask,
    output aux
  );

  modport packer (
    input  valid,
    output ready,
    input  result,
    input  status,
    input  tag,
    input  mask,
    input  aux
  );

endinterface

`default_nettype wire

// File: hw/fpslice_pkg.sv
`default_nettype none

package fpslice_pkg;

  // --------------------------------------------------
  // Formats and operations
  // --------------------------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned NUM_FORMATS  = 2;
  localparam int unsigned MAX_FP_WIDTH = 32;

  // One enable bit per format, indexed by fp_format_e
  typedef logic [NUM_FORMATS-1:0] fmt_logic_t;

  typedef enum logic [2:0] {
    FSGNJ  = 3'd0,
    FSGNJN = 3'd1,
    FSGNJX = 3'd2,
    FMIN   = 3'd3,
    FMAX   = 3'd4
  } op_e;

  // IEEE exception flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Travels with each item so the result can be packed at the output
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;
  } aux_t;

  typedef logic [7:0] tag_t;

  // --------------------------------------------------
  // Width helpers
  // --------------------------------------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP16) ? 16 : 32;
  endfunction

  function automatic int unsigned num_lanes(int unsigned width);
    return width / fp_width(FP16);
  endfunction

  // A format lives in a lane when the lane's slot still fits in the word
  function automatic fmt_logic_t lane_formats(int unsigned width, int unsigned lane);
    fmt_logic_t res;
    res = '0;
    for (int unsigned f = 0; f < NUM_FORMATS; f++) begin
      res[f] = ((lane + 1) * fp_width(fp_format_e'(f))) <= width;
    end
    return res;
  endfunction

  // Quiet NaN, right-aligned in the lane datapath
  function automatic logic [MAX_FP_WIDTH-1:0] canonical_nan(fp_format_e fmt);
    return (fmt == FP16) ? 32'h0000_7E00 : 32'h7FC0_0000;
  endfunction

endpackage

`default_nettype wire
